// ==== dv/decode_checks.svh ====
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

// lcg state, advanced on every draw
localparam logic [31:0] LCG_SEED = 32'd87790;
logic [31:0] lcg_state = LCG_SEED;

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

// x1..x31, never x0
function automatic arch_reg_t rand_reg();
	logic [31:0] r;
	r = lcg_next();
	return (r[20:16] % 5'd31) + 5'd1;
endfunction

function automatic logic [11:0] rand_imm12();
	logic [31:0] r;
	r = lcg_next();
	return r[27:16];
endfunction

// upper 20 bits for u and j immediates
function automatic logic [19:0] rand_imm20();
	logic [31:0] r;
	r = lcg_next();
	return r[31:12];
endfunction

// word-aligned target
function automatic addr_t rand_addr();
	logic [31:0] r;
	r = lcg_next();
	return {r[31:2], 2'b00};
endfunction

// instruction encoders, field order per the RV32I formats
function automatic insn_t enc_r(input funct7_t f7, input arch_reg_t rs2, input arch_reg_t rs1,
	input funct3_t f3, input arch_reg_t rd, input opcode_t opc);
	return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic insn_t enc_i(input logic [11:0] imm, input arch_reg_t rs1, input funct3_t f3,
	input arch_reg_t rd, input opcode_t opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic insn_t enc_s(input logic [11:0] imm, input arch_reg_t rs2,
	input arch_reg_t rs1, input funct3_t f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

// imm[0] is dropped by the format
function automatic insn_t enc_b(input logic [12:0] imm, input arch_reg_t rs2,
	input arch_reg_t rs1, input funct3_t f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic insn_t enc_u(input logic [19:0] imm, input arch_reg_t rd, input opcode_t opc);
	return {imm, rd, opc};
endfunction

function automatic insn_t enc_j(input logic [20:0] imm, input arch_reg_t rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

function automatic imm_t sext12(input logic [11:0] v);
	return {{20{v[11]}}, v};
endfunction

function automatic imm_t sext13(input logic [12:0] v);
	return {{19{v[12]}}, v};
endfunction

function automatic imm_t sext21(input logic [20:0] v);
	return {{11{v[20]}}, v};
endfunction

// each lane one 4-byte word after the lane before it
function automatic addr_t lane_pc(input addr_t pc, input int lane);
	return pc + 32'd4 * 32'(lane);
endfunction

// expected micro-ops, everything not named stays zero
function automatic uop_t exp_base(input uop_op_e op, input addr_t pc);
	uop_t u;
	u = '0;
	u.op = op;
	u.pc = pc;
	return u;
endfunction

function automatic uop_t exp_r(input uop_op_e op, input addr_t pc, input arch_reg_t rd,
	input arch_reg_t rs1, input arch_reg_t rs2);
	uop_t u;
	u = exp_base(op, pc);
	u.dst = rd;
	u.dst_valid = 1'b1;
	u.src_a = rs1;
	u.src_a_valid = 1'b1;
	u.src_b = rs2;
	u.src_b_valid = 1'b1;
	u.is_int = 1'b1;
	return u;
endfunction

function automatic uop_t exp_i(input uop_op_e op, input addr_t pc, input arch_reg_t rd,
	input arch_reg_t rs1, input imm_t imm);
	uop_t u;
	u = exp_base(op, pc);
	u.dst = rd;
	u.dst_valid = 1'b1;
	u.src_a = rs1;
	u.src_a_valid = 1'b1;
	u.rvimm = imm;
	u.is_int = 1'b1;
	return u;
endfunction

// loads go to the memory unit, not the integer unit
function automatic uop_t exp_load(input uop_op_e op, input addr_t pc, input arch_reg_t rd,
	input arch_reg_t rs1, input imm_t imm);
	uop_t u;
	u = exp_i(op, pc, rd, rs1, imm);
	u.is_int = 1'b0;
	u.is_mem = 1'b1;
	return u;
endfunction

function automatic uop_t exp_store(input uop_op_e op, input addr_t pc, input arch_reg_t rs1,
	input arch_reg_t rs2, input imm_t imm);
	uop_t u;
	u = exp_base(op, pc);
	u.src_a = rs1;
	u.src_a_valid = 1'b1;
	u.src_b = rs2;
	u.src_b_valid = 1'b1;
	u.rvimm = imm;
	u.is_mem = 1'b1;
	u.is_store = 1'b1;
	return u;
endfunction

function automatic uop_t exp_upper(input uop_op_e op, input addr_t pc, input arch_reg_t rd,
	input imm_t imm);
	uop_t u;
	u = exp_base(op, pc);
	u.dst = rd;
	u.dst_valid = 1'b1;
	u.rvimm = imm;
	u.is_int = 1'b1;
	return u;
endfunction

function automatic uop_t exp_branch(input uop_op_e op, input addr_t pc, input arch_reg_t rs1,
	input arch_reg_t rs2, input imm_t imm, input logic pred);
	uop_t u;
	u = exp_r(op, pc, '0, rs1, rs2);
	u.dst_valid = 1'b0;
	u.rvimm = imm;
	u.is_br = 1'b1;
	u.br_pred = pred;
	return u;
endfunction

// jumps are always predicted taken, destination only off x0
function automatic uop_t exp_jump(input uop_op_e op, input addr_t pc, input arch_reg_t rd,
	input arch_reg_t rs1, input logic rs1_used, input imm_t imm, input addr_t target);
	uop_t u;
	u = exp_base(op, pc);
	u.dst = rd;
	u.dst_valid = (rd != '0);
	u.src_a = rs1;
	u.src_a_valid = rs1_used;
	u.rvimm = imm;
	u.pred_target = target;
	u.is_int = 1'b1;
	u.is_br = 1'b1;
	u.br_pred = 1'b1;
	return u;
endfunction

// compare tasks, one per result kind
task automatic check_uop(input string name, input uop_t exp, input uop_t act);
	n_checks++;
	if (act !== exp)
	begin
		n_errors++;
		$display("Fail %s: expected %h actual %h", name, exp, act);
	end
endtask

task automatic check_op(input string name, input uop_op_e exp, input uop_op_e act);
	n_checks++;
	if (act !== exp)
	begin
		n_errors++;
		$display("Fail %s: expected %s actual %s", name, exp.name(), act.name());
	end
endtask

task automatic check_valid(input string name, input logic [N_LANES-1:0] exp,
	input logic [N_LANES-1:0] act);
	n_checks++;
	if (act !== exp)
	begin
		n_errors++;
		$display("Fail %s: expected valid %b actual valid %b", name, exp, act);
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	n_checks++;
	if (act !== exp)
	begin
		n_errors++;
		$display("Fail %s: expected %b actual %b", name, exp, act);
	end
endtask

`endif

// ==== dv/decode_tb.sv ====
`timescale 1ns/1ps

module decode_tb;
	import isa_pkg::*;
	import uop_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	// drive, idle, check, so three cycles per bundle at most
	localparam int MAX_BUNDLES = 48;
	localparam int TIMEOUT_NS = (RESET_CYCLES + 3 * MAX_BUNDLES) * CLK_PERIOD + 200;

	logic clk;
	logic rst;
	logic fetch_valid;
	addr_t fetch_pc;
	insn_t [N_LANES-1:0] fetch_insns;
	logic [N_LANES-1:0] fetch_pred;
	addr_t [N_LANES-1:0] fetch_pred_target;
	logic [N_LANES-1:0] uop_valid;
	uop_t [N_LANES-1:0] uops;
	int n_checks;
	int n_errors;
	// pc of the next bundle to drive
	addr_t next_pc;

	`include "decode_checks.svh"

	decode_stage u_dut
	(
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.fetch_insns(fetch_insns),
		.fetch_pred(fetch_pred),
		.fetch_pred_target(fetch_pred_target),
		.uop_valid(uop_valid),
		.uops(uops)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout, the decode tests did not finish in %0d ns", TIMEOUT_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	// one bundle on the falling edge, bundles step by two words
	task automatic send_bundle(input insn_t i0, input insn_t i1, input logic [N_LANES-1:0] pred,
		input addr_t pt0, input addr_t pt1);
		@(negedge clk);
		fetch_valid = 1'b1;
		fetch_pc = next_pc;
		fetch_insns[0] = i0;
		fetch_insns[1] = i1;
		fetch_pred = pred;
		fetch_pred_target[0] = pt0;
		fetch_pred_target[1] = pt1;
		next_pc = next_pc + 32'd8;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		fetch_valid = 1'b0;
	endtask

	// output is stable at the second falling edge after the drive
	task automatic run_bundle(input insn_t i0, input insn_t i1, input logic [N_LANES-1:0] pred,
		input addr_t pt0, input addr_t pt1, output addr_t pc);
		pc = next_pc;
		send_bundle(i0, i1, pred, pt0, pt1);
		idle_cycle();
		@(negedge clk);
	endtask

	task automatic test_alu();
		uop_op_e r_ops [10] = '{ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND};
		funct3_t r_f3 [10] = '{F3_ADD, F3_ADD, F3_SLL, F3_SLT, F3_SLTU, F3_XOR, F3_SR, F3_SR,
			F3_OR, F3_AND};
		uop_op_e i_ops [9] = '{ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, SRAI, ORI, ANDI};
		funct3_t i_f3 [9] = '{F3_ADD, F3_SLL, F3_SLT, F3_SLTU, F3_XOR, F3_SR, F3_SR, F3_OR, F3_AND};
		funct7_t f7;
		arch_reg_t rd;
		arch_reg_t rs1;
		arch_reg_t rs2;
		logic [11:0] imm;
		addr_t pc;
		string nm;
		// lane 1 repeats lane 0 with rd x0
		for (int i = 0; i < 10; i++)
		begin
			rd = rand_reg();
			rs1 = rand_reg();
			rs2 = rand_reg();
			nm = r_ops[i].name();
			f7 = (r_ops[i] == SUB || r_ops[i] == SRA) ? F7_ALT : F7_BASE;
			run_bundle(enc_r(f7, rs2, rs1, r_f3[i], rd, OPC_OP),
				enc_r(f7, rs2, rs1, r_f3[i], 5'd0, OPC_OP), '0, '0, '0, pc);
			check_valid(nm, 2'b11, uop_valid);
			check_uop(nm, exp_r(r_ops[i], lane_pc(pc, 0), rd, rs1, rs2), uops[0]);
			check_op({nm, " rd x0"}, NOP, uops[1].op);
			check_flag({nm, " rd x0 dst_valid"}, 1'b0, uops[1].dst_valid);
		end
		for (int i = 0; i < 9; i++)
		begin
			rd = rand_reg();
			rs1 = rand_reg();
			nm = i_ops[i].name();
			// shifts carry funct7 in the upper immediate bits
			if (i_f3[i] == F3_SLL || i_f3[i] == F3_SR)
				imm = {(i_ops[i] == SRAI) ? F7_ALT : F7_BASE, rand_reg()};
			else
				imm = rand_imm12();
			run_bundle(enc_i(imm, rs1, i_f3[i], rd, OPC_OP_IMM),
				enc_i(imm, rs1, i_f3[i], 5'd0, OPC_OP_IMM), '0, '0, '0, pc);
			check_valid(nm, 2'b11, uop_valid);
			check_uop(nm, exp_i(i_ops[i], lane_pc(pc, 0), rd, rs1, sext12(imm)), uops[0]);
			check_op({nm, " rd x0"}, NOP, uops[1].op);
			check_flag({nm, " rd x0 dst_valid"}, 1'b0, uops[1].dst_valid);
		end
	endtask

	task automatic test_mem_upper();
		uop_op_e ld_ops [5] = '{LB, LH, LW, LBU, LHU};
		funct3_t ld_f3 [5] = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};
		uop_op_e st_ops [3] = '{SB, SH, SW};
		funct3_t st_f3 [3] = '{F3_B, F3_H, F3_W};
		arch_reg_t rd;
		arch_reg_t rs1;
		arch_reg_t rs2;
		logic [11:0] imm;
		logic [11:0] simm;
		logic [19:0] uimm0;
		logic [19:0] uimm1;
		addr_t pc;
		int j;
		for (int i = 0; i < 5; i++)
		begin
			rd = rand_reg();
			rs1 = rand_reg();
			rs2 = rand_reg();
			imm = rand_imm12();
			simm = rand_imm12();
			j = i % 3;
			run_bundle(enc_i(imm, rs1, ld_f3[i], rd, OPC_LOAD), enc_s(simm, rs2, rs1, st_f3[j]),
				'0, '0, '0, pc);
			check_valid(ld_ops[i].name(), 2'b11, uop_valid);
			check_uop(ld_ops[i].name(), exp_load(ld_ops[i], lane_pc(pc, 0), rd, rs1, sext12(imm)),
				uops[0]);
			check_uop(st_ops[j].name(), exp_store(st_ops[j], lane_pc(pc, 1), rs1, rs2, sext12(simm)),
				uops[1]);
		end
		rd = rand_reg();
		rs1 = rand_reg();
		uimm0 = rand_imm20();
		uimm1 = rand_imm20();
		run_bundle(enc_u(uimm0, rd, OPC_LUI), enc_u(uimm1, rs1, OPC_AUIPC), '0, '0, '0, pc);
		check_valid("LUI/AUIPC", 2'b11, uop_valid);
		check_uop("LUI", exp_upper(LUI, lane_pc(pc, 0), rd, {uimm0, 12'd0}), uops[0]);
		check_uop("AUIPC", exp_upper(AUIPC, lane_pc(pc, 1), rs1, {uimm1, 12'd0}), uops[1]);
	endtask

	task automatic test_branch();
		uop_op_e b_ops [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
		funct3_t b_f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
		arch_reg_t rs1;
		arch_reg_t rs2;
		logic [12:0] bimm0;
		logic [12:0] bimm1;
		logic [N_LANES-1:0] pred;
		addr_t pc;
		for (int i = 0; i < 6; i++)
		begin
			rs1 = rand_reg();
			rs2 = rand_reg();
			bimm0 = {rand_imm12(), 1'b0};
			bimm1 = {rand_imm12(), 1'b0};
			// lanes get opposite predictions
			pred = i[0] ? 2'b01 : 2'b10;
			run_bundle(enc_b(bimm0, rs2, rs1, b_f3[i]), enc_b(bimm1, rs1, rs2, b_f3[5 - i]),
				pred, '0, '0, pc);
			check_valid(b_ops[i].name(), 2'b11, uop_valid);
			check_uop(b_ops[i].name(), exp_branch(b_ops[i], lane_pc(pc, 0), rs1, rs2,
				sext13(bimm0), pred[0]), uops[0]);
			check_uop(b_ops[5 - i].name(), exp_branch(b_ops[5 - i], lane_pc(pc, 1), rs2, rs1,
				sext13(bimm1), pred[1]), uops[1]);
		end
	endtask

	task automatic test_jumps();
		arch_reg_t rd;
		arch_reg_t rs1;
		arch_reg_t rs2;
		logic [20:0] jimm0;
		logic [20:0] jimm1;
		logic [11:0] imm0;
		logic [11:0] imm1;
		addr_t pt0;
		addr_t pt1;
		addr_t pc;
		rd = rand_reg();
		jimm0 = {rand_imm20(), 1'b0};
		jimm1 = {rand_imm20(), 1'b0};
		// predictor says not taken, decode overrides
		run_bundle(enc_j(jimm0, rd), enc_j(jimm1, 5'd0), '0, '0, '0, pc);
		check_valid("JAL/J", 2'b11, uop_valid);
		check_uop("JAL", exp_jump(JAL, lane_pc(pc, 0), rd, '0, 1'b0, sext21(jimm0), '0), uops[0]);
		check_uop("J", exp_jump(J, lane_pc(pc, 1), '0, '0, 1'b0, sext21(jimm1), '0), uops[1]);
		rd = rand_reg();
		rs1 = rand_reg();
		rs2 = rand_reg();
		imm0 = rand_imm12();
		imm1 = rand_imm12();
		pt0 = rand_addr();
		pt1 = rand_addr();
		run_bundle(enc_i(imm0, rs1, 3'd0, rd, OPC_JALR), enc_i(imm1, rs2, 3'd0, 5'd0, OPC_JALR),
			'0, pt0, pt1, pc);
		check_valid("JALR/JR", 2'b11, uop_valid);
		check_uop("JALR", exp_jump(JALR, lane_pc(pc, 0), rd, rs1, 1'b1, sext12(imm0), pt0), uops[0]);
		check_uop("JR", exp_jump(JR, lane_pc(pc, 1), '0, rs2, 1'b1, sext12(imm1), pt1), uops[1]);
	endtask

	task automatic test_misc();
		arch_reg_t rd;
		arch_reg_t rs1;
		arch_reg_t rs2;
		addr_t pc;
		insn_t add_insn;
		rd = rand_reg();
		rs1 = rand_reg();
		rs2 = rand_reg();
		add_insn = enc_r(F7_BASE, rs2, rs1, F3_ADD, rd, OPC_OP);
		// fence and a csr access
		run_bundle(enc_i(12'h0ff, '0, 3'd0, '0, OPC_MISC_MEM), enc_i(12'h300, rs1, 3'd1, rd,
			OPC_SYSTEM), '0, '0, '0, pc);
		check_valid("FENCE/CSR", 2'b11, uop_valid);
		check_op("FENCE", NOP, uops[0].op);
		check_op("CSRRW", NOP, uops[1].op);
		// ecall in lane 0 holds back lane 1
		run_bundle(32'h0000_0073, add_insn, '0, '0, '0, pc);
		check_valid("ECALL lane 0", 2'b01, uop_valid);
		check_op("ECALL lane 0", BREAK, uops[0].op);
		check_flag("ECALL lane 0 serializing", 1'b1, uops[0].serializing);
		run_bundle(add_insn, 32'h0000_0073, '0, '0, '0, pc);
		check_valid("ECALL lane 1", 2'b11, uop_valid);
		check_op("ECALL lane 1", BREAK, uops[1].op);
		run_bundle(32'h0010_0073, enc_i(rand_imm12(), rs1, 3'd0, rd, 7'h0b), '0, '0, '0, pc);
		check_valid("EBREAK/custom", 2'b11, uop_valid);
		check_op("EBREAK", NOP, uops[0].op);
		check_op("custom opcode", II, uops[1].op);
		// bad funct codes on known opcodes
		run_bundle(enc_r(7'h01, rs2, rs1, F3_ADD, rd, OPC_OP), enc_i(rand_imm12(), rs1, 3'd3, rd,
			OPC_LOAD), '0, '0, '0, pc);
		check_op("OP funct7 01", II, uops[0].op);
		check_op("LOAD funct3 3", II, uops[1].op);
		run_bundle(enc_s(rand_imm12(), rs2, rs1, 3'd3), enc_i({F7_ALT, rs2}, rs1, F3_SLL, rd,
			OPC_OP_IMM), '0, '0, '0, pc);
		check_op("STORE funct3 3", II, uops[0].op);
		check_op("SLLI funct7 20", II, uops[1].op);
	endtask

	task automatic check_addi_pair(input string nm, input addr_t pc,
		input arch_reg_t [N_LANES-1:0] rds, input arch_reg_t [N_LANES-1:0] rs1s,
		input logic [N_LANES-1:0][11:0] imms);
		check_valid(nm, 2'b11, uop_valid);
		for (int l = 0; l < N_LANES; l++)
			check_uop(nm, exp_i(ADDI, lane_pc(pc, l), rds[l], rs1s[l], sext12(imms[l])), uops[l]);
	endtask

	// three bundles on consecutive cycles
	task automatic test_back_to_back();
		arch_reg_t [2:0][N_LANES-1:0] rds;
		arch_reg_t [2:0][N_LANES-1:0] rs1s;
		logic [2:0][N_LANES-1:0][11:0] imms;
		insn_t [2:0][N_LANES-1:0] ins;
		addr_t pcs [3];
		for (int b = 0; b < 3; b++)
		begin
			for (int l = 0; l < N_LANES; l++)
			begin
				rds[b][l] = rand_reg();
				rs1s[b][l] = rand_reg();
				imms[b][l] = rand_imm12();
				ins[b][l] = enc_i(imms[b][l], rs1s[b][l], F3_ADD, rds[b][l], OPC_OP_IMM);
			end
		end
		pcs[0] = next_pc;
		send_bundle(ins[0][0], ins[0][1], '0, '0, '0);
		pcs[1] = next_pc;
		send_bundle(ins[1][0], ins[1][1], '0, '0, '0);
		// one cycle in, nothing may show yet
		check_valid("b2b early", 2'b00, uop_valid);
		pcs[2] = next_pc;
		send_bundle(ins[2][0], ins[2][1], '0, '0, '0);
		check_addi_pair("b2b bundle 0", pcs[0], rds[0], rs1s[0], imms[0]);
		idle_cycle();
		check_addi_pair("b2b bundle 1", pcs[1], rds[1], rs1s[1], imms[1]);
		@(negedge clk);
		check_addi_pair("b2b bundle 2", pcs[2], rds[2], rs1s[2], imms[2]);
		@(negedge clk);
		check_valid("b2b drained", 2'b00, uop_valid);
	endtask

	initial
	begin
		n_checks = 0;
		n_errors = 0;
		next_pc = 32'h0000_1000;
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_pc = '0;
		fetch_insns = '0;
		fetch_pred = '0;
		fetch_pred_target = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_valid("after reset", 2'b00, uop_valid);
		test_alu();
		test_mem_upper();
		test_branch();
		test_jumps();
		test_misc();
		test_back_to_back();
		$display("decode_tb: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+dv
src/isa_pkg.sv
src/uop_pkg.sv
src/fetch_lane_if.sv
src/uop_lane_if.sv
src/fetch_bundle_latch.sv
src/riscv_decoder.sv
src/decode_out_reg.sv
src/decode_stage.sv
dv/decode_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -sv --assert --top-module decode_tb \
	-f project.f -Mdir "$BUILD_DIR" -o decode_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/decode_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== src/decode_out_reg.sv ====
`timescale 1ns/1ps

// pipeline register between decode and rename
module decode_out_reg
(
	input logic clk,
	input logic rst,
	uop_lane_if.dst lanes_in [isa_pkg::N_LANES],
	output logic [isa_pkg::N_LANES-1:0] uop_valid,
	output uop_pkg::uop_t [isa_pkg::N_LANES-1:0] uops
);
	import isa_pkg::*;
	import uop_pkg::*;

	logic [N_LANES-1:0] lane_valid;
	uop_t [N_LANES-1:0] lane_uop;
	logic lane0_serial;
	// lane valids after squash
	logic [N_LANES-1:0] issue;

	for (genvar i = 0; i < N_LANES; i++)
	begin : g_gather
		assign lane_valid[i] = lanes_in[i].valid;
		assign lane_uop[i] = lanes_in[i].uop;
	end

	assign lane0_serial = lane_valid[0] && lane_uop[0].serializing;

	// younger lanes wait for a refetch after a serializing lane 0
	always_comb
	begin
		issue = lane_valid;
		if (lane0_serial)
			issue[N_LANES-1:1] = '0;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			uop_valid <= '0;
		else
			uop_valid <= issue;
	end

	always_ff @(posedge clk)
	begin
		uops <= lane_uop;
	end

	// nothing rides behind a serializing op into rename
	a_serial_alone: assert property (@(posedge clk) disable iff (rst)
		(uop_valid[0] && uops[0].serializing) |-> (uop_valid[N_LANES-1:1] == '0));

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

// two-wide decode, fetch bundle in and registered micro-ops out
module decode_stage
(
	input logic clk,
	input logic rst,
	input logic fetch_valid,
	input isa_pkg::addr_t fetch_pc,
	input isa_pkg::insn_t [isa_pkg::N_LANES-1:0] fetch_insns,
	input logic [isa_pkg::N_LANES-1:0] fetch_pred,
	input isa_pkg::addr_t [isa_pkg::N_LANES-1:0] fetch_pred_target,
	output logic [isa_pkg::N_LANES-1:0] uop_valid,
	output uop_pkg::uop_t [isa_pkg::N_LANES-1:0] uops
);
	import isa_pkg::*;

	// latch to decoder
	fetch_lane_if fetch_lanes [N_LANES] ();
	// decoder to output register
	uop_lane_if uop_lanes [N_LANES] ();

	fetch_bundle_latch u_latch
	(
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.fetch_insns(fetch_insns),
		.fetch_pred(fetch_pred),
		.fetch_pred_target(fetch_pred_target),
		.lanes(fetch_lanes)
	);

	// one identical decoder per lane
	for (genvar i = 0; i < N_LANES; i++)
	begin : g_dec
		riscv_decoder u_dec
		(
			.fl(fetch_lanes[i]),
			.ul(uop_lanes[i])
		);
	end

	decode_out_reg u_out
	(
		.clk(clk),
		.rst(rst),
		.lanes_in(uop_lanes),
		.uop_valid(uop_valid),
		.uops(uops)
	);

endmodule

// ==== src/fetch_bundle_latch.sv ====
`timescale 1ns/1ps

// captures the fetch bundle and splits it into per-lane records
module fetch_bundle_latch
(
	input logic clk,
	input logic rst,
	input logic fetch_valid,
	input isa_pkg::addr_t fetch_pc,
	input isa_pkg::insn_t [isa_pkg::N_LANES-1:0] fetch_insns,
	input logic [isa_pkg::N_LANES-1:0] fetch_pred,
	input isa_pkg::addr_t [isa_pkg::N_LANES-1:0] fetch_pred_target,
	fetch_lane_if.src lanes [isa_pkg::N_LANES]
);
	import isa_pkg::*;

	logic bundle_valid;
	addr_t bundle_pc;
	insn_t [N_LANES-1:0] bundle_insns;
	logic [N_LANES-1:0] bundle_pred;
	addr_t [N_LANES-1:0] bundle_pred_target;

	always_ff @(posedge clk)
	begin
		if (rst)
			bundle_valid <= 1'b0;
		else
			bundle_valid <= fetch_valid;
	end

	// payload only moves with a valid bundle
	always_ff @(posedge clk)
	begin
		if (fetch_valid)
		begin
			bundle_pc <= fetch_pc;
			bundle_insns <= fetch_insns;
			bundle_pred <= fetch_pred;
			bundle_pred_target <= fetch_pred_target;
		end
	end

	// whole bundle is valid or not, lanes never split here
	for (genvar i = 0; i < N_LANES; i++)
	begin : g_lane
		assign lanes[i].valid = bundle_valid;
		assign lanes[i].insn = bundle_insns[i];
		// lane i sits i words past the bundle pc
		assign lanes[i].pc = bundle_pc + addr_t'(i * INSN_BYTES);
		assign lanes[i].pred = bundle_pred[i];
		assign lanes[i].pred_target = bundle_pred_target[i];
	end

	// fetch hands over word-aligned bundles only
	a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
		fetch_valid |-> ((fetch_pc & addr_t'(INSN_BYTES - 1)) == '0));

endmodule

// ==== src/fetch_lane_if.sv ====
`timescale 1ns/1ps

// one lane of the latched fetch bundle
interface fetch_lane_if;
	import isa_pkg::*;

	logic valid;
	insn_t insn;
	// pc of this instruction, not of the bundle
	addr_t pc;
	// predictor state captured at fetch
	logic pred;
	addr_t pred_target;

	// bundle latch side
	modport src
	(
		output valid,
		output insn,
		output pc,
		output pred,
		output pred_target
	);

	// decoder side
	modport dst
	(
		input valid,
		input insn,
		input pc,
		input pred,
		input pred_target
	);

endinterface

// ==== src/isa_pkg.sv ====
package isa_pkg;

	// raw fetch words and addresses
	typedef logic [31:0] insn_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0] arch_reg_t;
	// immediates after sign extension
	typedef logic [31:0] imm_t;

	// instruction fields
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	// major opcodes, insn[6:0]
	localparam opcode_t OPC_LOAD = 7'h03;
	localparam opcode_t OPC_MISC_MEM = 7'h0f;
	localparam opcode_t OPC_OP_IMM = 7'h13;
	localparam opcode_t OPC_AUIPC = 7'h17;
	localparam opcode_t OPC_STORE = 7'h23;
	localparam opcode_t OPC_OP = 7'h33;
	localparam opcode_t OPC_LUI = 7'h37;
	localparam opcode_t OPC_BRANCH = 7'h63;
	localparam opcode_t OPC_JALR = 7'h67;
	localparam opcode_t OPC_JAL = 7'h6f;
	localparam opcode_t OPC_SYSTEM = 7'h73;

	// load/store access size, stores use B/H/W only
	localparam funct3_t F3_B = 3'd0;
	localparam funct3_t F3_H = 3'd1;
	localparam funct3_t F3_W = 3'd2;
	localparam funct3_t F3_BU = 3'd4;
	localparam funct3_t F3_HU = 3'd5;

	// alu funct3, shared by OP and OP-IMM
	localparam funct3_t F3_ADD = 3'd0;
	localparam funct3_t F3_SLL = 3'd1;
	localparam funct3_t F3_SLT = 3'd2;
	localparam funct3_t F3_SLTU = 3'd3;
	localparam funct3_t F3_XOR = 3'd4;
	localparam funct3_t F3_SR = 3'd5;
	localparam funct3_t F3_OR = 3'd6;
	localparam funct3_t F3_AND = 3'd7;

	// branch conditions
	localparam funct3_t F3_BEQ = 3'd0;
	localparam funct3_t F3_BNE = 3'd1;
	localparam funct3_t F3_BLT = 3'd4;
	localparam funct3_t F3_BGE = 3'd5;
	localparam funct3_t F3_BLTU = 3'd6;
	localparam funct3_t F3_BGEU = 3'd7;

	// base form and the SUB/SRA form
	localparam funct7_t F7_BASE = 7'h00;
	localparam funct7_t F7_ALT = 7'h20;

	// two instructions per fetch bundle
	localparam int N_LANES = 2;
	localparam int INSN_BYTES = 4;

endpackage

// ==== src/riscv_decoder.sv ====
`timescale 1ns/1ps

// RV32I decode of one lane, no state
module riscv_decoder
(
	fetch_lane_if.dst fl,
	uop_lane_if.src ul
);
	import isa_pkg::*;
	import uop_pkg::*;

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;
	arch_reg_t rd;
	arch_reg_t rs1;
	arch_reg_t rs2;
	logic rd_nz;
	logic f7_base;
	logic f7_alt;
	// immediate formats, all sign extended
	imm_t imm_i;
	imm_t imm_s;
	imm_t imm_b;
	imm_t imm_u;
	imm_t imm_j;
	// op is one that turns into NOP when rd is x0
	logic rd_gated;
	uop_t uop;

	assign opcode = fl.insn[6:0];
	assign rd = fl.insn[11:7];
	assign funct3 = fl.insn[14:12];
	assign rs1 = fl.insn[19:15];
	assign rs2 = fl.insn[24:20];
	assign funct7 = fl.insn[31:25];
	assign rd_nz = (rd != '0);
	assign f7_base = (funct7 == F7_BASE);
	assign f7_alt = (funct7 == F7_ALT);

	assign imm_i = {{20{fl.insn[31]}}, fl.insn[31:20]};
	assign imm_s = {{20{fl.insn[31]}}, fl.insn[31:25], fl.insn[11:7]};
	assign imm_b = {{19{fl.insn[31]}}, fl.insn[31], fl.insn[7], fl.insn[30:25],
		fl.insn[11:8], 1'b0};
	assign imm_u = {fl.insn[31:12], 12'd0};
	assign imm_j = {{11{fl.insn[31]}}, fl.insn[31], fl.insn[19:12], fl.insn[20],
		fl.insn[30:21], 1'b0};

	always_comb
	begin
		uop = '0;
		uop.op = II;
		uop.pc = fl.pc;
		rd_gated = 1'b0;
		case (opcode)
			OPC_LOAD:
			begin
				uop.dst = rd;
				uop.dst_valid = rd_nz;
				uop.src_a = rs1;
				// no base read needed when the load is dropped
				uop.src_a_valid = rd_nz;
				uop.is_mem = 1'b1;
				uop.rvimm = imm_i;
				rd_gated = 1'b1;
				case (funct3)
					F3_B: uop.op = LB;
					F3_H: uop.op = LH;
					F3_W: uop.op = LW;
					F3_BU: uop.op = LBU;
					F3_HU: uop.op = LHU;
					default: uop.op = II;
				endcase
			end
			// fence, nothing to order in this core
			OPC_MISC_MEM: uop.op = NOP;
			OPC_OP_IMM:
			begin
				uop.dst = rd;
				uop.dst_valid = rd_nz;
				uop.src_a = rs1;
				uop.src_a_valid = rd_nz;
				uop.is_int = 1'b1;
				// shifts keep funct7 in the upper imm bits
				uop.rvimm = imm_i;
				rd_gated = 1'b1;
				case (funct3)
					F3_ADD: uop.op = ADDI;
					F3_SLL: uop.op = f7_base ? SLLI : II;
					F3_SLT: uop.op = SLTI;
					F3_SLTU: uop.op = SLTIU;
					F3_XOR: uop.op = XORI;
					F3_SR: uop.op = f7_base ? SRLI : (f7_alt ? SRAI : II);
					F3_OR: uop.op = ORI;
					F3_AND: uop.op = ANDI;
				endcase
			end
			OPC_AUIPC,
			OPC_LUI:
			begin
				uop.op = (opcode == OPC_LUI) ? LUI : AUIPC;
				uop.dst = rd;
				uop.dst_valid = rd_nz;
				uop.is_int = 1'b1;
				uop.rvimm = imm_u;
				rd_gated = 1'b1;
			end
			OPC_STORE:
			begin
				// base in src_a, store data in src_b
				uop.src_a = rs1;
				uop.src_b = rs2;
				uop.src_a_valid = 1'b1;
				uop.src_b_valid = 1'b1;
				uop.is_mem = 1'b1;
				uop.is_store = 1'b1;
				uop.rvimm = imm_s;
				case (funct3)
					F3_B: uop.op = SB;
					F3_H: uop.op = SH;
					F3_W: uop.op = SW;
					default: uop.op = II;
				endcase
			end
			OPC_OP:
			begin
				uop.dst = rd;
				uop.dst_valid = rd_nz;
				uop.src_a = rs1;
				uop.src_b = rs2;
				uop.src_a_valid = 1'b1;
				uop.src_b_valid = 1'b1;
				uop.is_int = 1'b1;
				rd_gated = 1'b1;
				case (funct3)
					F3_ADD: uop.op = f7_base ? ADD : (f7_alt ? SUB : II);
					F3_SLL: uop.op = f7_base ? SLL : II;
					F3_SLT: uop.op = f7_base ? SLT : II;
					F3_SLTU: uop.op = f7_base ? SLTU : II;
					F3_XOR: uop.op = f7_base ? XOR : II;
					F3_SR: uop.op = f7_base ? SRL : (f7_alt ? SRA : II);
					F3_OR: uop.op = f7_base ? OR : II;
					F3_AND: uop.op = f7_base ? AND : II;
				endcase
			end
			OPC_BRANCH:
			begin
				uop.src_a = rs1;
				uop.src_b = rs2;
				uop.src_a_valid = 1'b1;
				uop.src_b_valid = 1'b1;
				uop.is_int = 1'b1;
				uop.is_br = 1'b1;
				uop.rvimm = imm_b;
				// direction comes straight from the fetch predictor
				uop.br_pred = fl.pred;
				case (funct3)
					F3_BEQ: uop.op = BEQ;
					F3_BNE: uop.op = BNE;
					F3_BLT: uop.op = BLT;
					F3_BGE: uop.op = BGE;
					F3_BLTU: uop.op = BLTU;
					F3_BGEU: uop.op = BGEU;
					default: uop.op = II;
				endcase
			end
			OPC_JALR:
			begin
				uop.op = rd_nz ? JALR : JR;
				uop.dst = rd;
				uop.dst_valid = rd_nz;
				uop.src_a = rs1;
				uop.src_a_valid = 1'b1;
				uop.is_int = 1'b1;
				uop.is_br = 1'b1;
				uop.br_pred = 1'b1;
				uop.rvimm = imm_i;
				// indirect, so execute checks against fetch's guess
				uop.pred_target = fl.pred_target;
			end
			OPC_JAL:
			begin
				uop.op = rd_nz ? JAL : J;
				uop.dst = rd;
				uop.dst_valid = rd_nz;
				uop.is_int = 1'b1;
				uop.is_br = 1'b1;
				uop.br_pred = 1'b1;
				uop.rvimm = imm_j;
			end
			OPC_SYSTEM:
			begin
				uop.is_int = 1'b1;
				// ecall form traps as break, csr and the rest ignored
				if (fl.insn[31:7] == '0)
				begin
					uop.op = BREAK;
					uop.serializing = 1'b1;
				end
				else
					uop.op = NOP;
			end
			default: uop.op = II;
		endcase
		// writes to x0 vanish, illegal encodings stay illegal
		if (rd_gated && !rd_nz && (uop.op != II))
			uop.op = NOP;
	end

	assign ul.valid = fl.valid;
	assign ul.uop = uop;

	// rename would map x0 otherwise
	always_comb
	begin
		if (fl.valid)
			a_no_x0_dst: assert (!(uop.dst_valid && (uop.dst == '0)));
	end

endmodule

// ==== src/uop_lane_if.sv ====
`timescale 1ns/1ps

// decoded micro-op of one lane
interface uop_lane_if;
	import uop_pkg::*;

	logic valid;
	uop_t uop;

	// decoder drives
	modport src
	(
		output valid,
		output uop
	);

	// output register samples
	modport dst
	(
		input valid,
		input uop
	);

endinterface

// ==== src/uop_pkg.sv ====
package uop_pkg;
	import isa_pkg::*;

	// II must stay at zero, a cleared uop reads as illegal
	typedef enum logic [5:0]
	{
		II,
		NOP,
		// loads
		LB, LH, LW, LBU, LHU,
		// stores
		SB, SH, SW,
		// register-immediate alu
		ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, SRAI, ORI, ANDI,
		// upper immediates
		LUI, AUIPC,
		// register-register alu
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		// conditional branches
		BEQ, BNE, BLT, BGE, BLTU, BGEU,
		// jumps, J and JR are the rd == x0 forms
		JAL, J, JALR, JR,
		// ecall with all-zero upper field
		BREAK
	} uop_op_e;

	// one decoded micro-op as handed to rename
	typedef struct packed
	{
		uop_op_e op;
		addr_t pc;
		// architectural register numbers
		arch_reg_t dst;
		logic dst_valid;
		arch_reg_t src_a;
		logic src_a_valid;
		arch_reg_t src_b;
		logic src_b_valid;
		imm_t rvimm;
		// fetch-predicted target, JALR/JR only
		addr_t pred_target;
		logic br_pred;
		logic is_br;
		// execution class
		logic is_mem;
		logic is_int;
		logic is_store;
		// drain the window before this issues
		logic serializing;
	} uop_t;

endpackage
